// ==== common/video_pkg.sv ====
package video_pkg;

	localparam int CNT_W     = 11; // Raster counters and limits
	localparam int SW_W      = 4;  // Format switch code
	localparam int CLK_SET_W = 8;  // Pixel clock M and D
	localparam int COLOR_W   = 8;  // One colour channel
	localparam int NUM_FMT   = 6;

	// Display formats in table row order
	typedef enum logic [2:0] {
		fmt_vga,
		fmt_svga,
		fmt_xga,
		fmt_hdtv720p,
		fmt_sxga,
		fmt_camera
	} video_format_e;

	////////////////////
	// Switch codes
	////////////////////
	localparam logic [SW_W-1:0] SW_VGA      = 4'b0000;
	localparam logic [SW_W-1:0] SW_SVGA     = 4'b0001;
	localparam logic [SW_W-1:0] SW_HDTV720P = 4'b0010;
	localparam logic [SW_W-1:0] SW_XGA      = 4'b0011;
	localparam logic [SW_W-1:0] SW_SXGA     = 4'b1000;
	localparam logic [SW_W-1:0] SW_CAMERA   = 4'b1001;

	////////////////////
	// Timing tables
	////////////////////
	// Rows follow video_format_e
	localparam logic [CNT_W-1:0] H_PIXELS [NUM_FMT] =
		'{11'd640, 11'd800, 11'd1024, 11'd1280, 11'd1280, 11'd1280};
	localparam logic [CNT_W-1:0] V_LINES [NUM_FMT] =
		'{11'd480, 11'd600, 11'd768, 11'd720, 11'd1024, 11'd720};
	localparam logic [CNT_W-1:0] H_FPORCH [NUM_FMT] =
		'{11'd16, 11'd40, 11'd24, 11'd110, 11'd48, 11'd110};
	localparam logic [CNT_W-1:0] H_SYNC_PW [NUM_FMT] =
		'{11'd96, 11'd128, 11'd136, 11'd40, 11'd112, 11'd39};
	localparam logic [CNT_W-1:0] H_BPORCH [NUM_FMT] =
		'{11'd48, 11'd88, 11'd160, 11'd220, 11'd248, 11'd220};
	localparam logic [CNT_W-1:0] V_FPORCH [NUM_FMT] =
		'{11'd10, 11'd1, 11'd3, 11'd5, 11'd1, 11'd4};
	localparam logic [CNT_W-1:0] V_SYNC_PW [NUM_FMT] =
		'{11'd2, 11'd4, 11'd6, 11'd5, 11'd3, 11'd4};
	localparam logic [CNT_W-1:0] V_BPORCH [NUM_FMT] =
		'{11'd33, 11'd23, 11'd29, 11'd20, 11'd38, 11'd22};

	localparam logic SYNC_NEG [NUM_FMT] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0}; // 1 is negative

	// DCM M and D, one below the real ratio
	localparam logic [CLK_SET_W-1:0] PCLK_M [NUM_FMT] =
		'{8'd1, 8'd3, 8'd12, 8'd247, 8'd53, 8'd134};
	localparam logic [CLK_SET_W-1:0] PCLK_D [NUM_FMT] =
		'{8'd3, 8'd4, 8'd9, 8'd166, 8'd24, 8'd90};

	// Eight bars across the active line
	localparam logic [CNT_W-1:0] BAR_WIDTH [NUM_FMT] =
		'{11'd80, 11'd100, 11'd128, 11'd160, 11'd160, 11'd160};

	localparam logic [3*COLOR_W-1:0] BAR_RGB [8] = '{
		24'hFFFFFF, // White
		24'hFFFF00, // Yellow
		24'h00FFFF, // Cyan
		24'h00FF00, // Green
		24'hFF00FF, // Magenta
		24'hFF0000, // Red
		24'h0000FF, // Blue
		24'h000000  // Black
	};

	// Switch code to format
	function automatic video_format_e decode_format(input logic [SW_W-1:0] code);
		video_format_e fmt;
		case (code)
			SW_VGA:      fmt = fmt_vga;
			SW_SVGA:     fmt = fmt_svga;
			SW_XGA:      fmt = fmt_xga;
			SW_HDTV720P: fmt = fmt_hdtv720p;
			SW_SXGA:     fmt = fmt_sxga;
			SW_CAMERA:   fmt = fmt_camera;
			default:     fmt = fmt_hdtv720p; // Undefined codes fall back to 720p
		endcase
		return fmt;
	endfunction

endpackage

// ==== logic/switch_conditioner.sv ====
`timescale 1ns/1ps

module switch_conditioner #(
	parameter int DEBOUNCE_CYCLES = 500000
) (
	input  logic                       clk50m_bufg,
	input  logic                       RSTBTN,
	input  logic [video_pkg::SW_W-1:0] sw,
	output logic [video_pkg::SW_W-1:0] sw_stable,
	output logic                       sw_changed
);

	import video_pkg::*;

	localparam int HOLD_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [HOLD_W-1:0] HOLD_MAX = HOLD_W'(DEBOUNCE_CYCLES);

	logic [SW_W-1:0]   sw_meta;   // First synchronizer flop
	logic [SW_W-1:0]   sw_sync;   // Second flop
	logic [SW_W-1:0]   candidate; // Code being timed
	logic [HOLD_W-1:0] hold_cnt;
	logic              held;      // Candidate has been steady long enough

	////////////////////
	// Synchronizer
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta <= '0;
			sw_sync <= '0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
		end
	end

	////////////////////
	// Debounce
	////////////////////
	assign held = (hold_cnt == HOLD_MAX);

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			candidate <= '0;
			hold_cnt  <= '0;
		end else if (sw_sync != candidate) begin
			candidate <= sw_sync; // Any bounce restarts the hold time
			hold_cnt  <= '0;
		end else if (!held) begin
			hold_cnt <= hold_cnt + 1'b1; // Saturates at HOLD_MAX
		end
	end

	// Publish only a real change of code
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_stable  <= '0;
			sw_changed <= 1'b0;
		end else begin
			sw_changed <= 1'b0;
			if (held && (candidate != sw_stable)) begin
				sw_stable  <= candidate;
				sw_changed <= 1'b1;
			end
		end
	end

	// One pulse per accepted code
	assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		sw_changed |=> !sw_changed);

endmodule

// ==== logic/format_select.sv ====
`timescale 1ns/1ps

module format_select (
	input  logic                            clk50m_bufg,
	input  logic                            RSTBTN,
	input  logic [video_pkg::SW_W-1:0]      sw_stable,
	input  logic                            sw_changed,
	output logic [video_pkg::CNT_W-1:0]     hs_blank,
	output logic [video_pkg::CNT_W-1:0]     hs_sync,
	output logic [video_pkg::CNT_W-1:0]     he_sync,
	output logic [video_pkg::CNT_W-1:0]     he_blank,
	output logic [video_pkg::CNT_W-1:0]     vs_blank,
	output logic [video_pkg::CNT_W-1:0]     vs_sync,
	output logic [video_pkg::CNT_W-1:0]     ve_sync,
	output logic [video_pkg::CNT_W-1:0]     ve_blank,
	output logic                            sync_neg,
	output logic [video_pkg::CNT_W-1:0]     bar_width,
	output logic [video_pkg::CLK_SET_W-1:0] pclk_m,
	output logic [video_pkg::CLK_SET_W-1:0] pclk_d,
	output logic                            restart
);

	import video_pkg::*;

	video_format_e    load_fmt; // Table row to load
	logic             load_en;
	logic [CNT_W-1:0] hs_blank_d;
	logic [CNT_W-1:0] hs_sync_d;
	logic [CNT_W-1:0] he_sync_d;
	logic [CNT_W-1:0] he_blank_d;
	logic [CNT_W-1:0] vs_blank_d;
	logic [CNT_W-1:0] vs_sync_d;
	logic [CNT_W-1:0] ve_sync_d;
	logic [CNT_W-1:0] ve_blank_d;

	// Reset comes up in VGA
	assign load_fmt = RSTBTN ? fmt_vga : decode_format(sw_stable);
	assign load_en  = RSTBTN | sw_changed;

	////////////////////
	// Limit sums
	////////////////////
	// Last live pixel, then front porch, sync and back porch
	assign hs_blank_d = H_PIXELS[load_fmt] - CNT_W'(1);
	assign hs_sync_d  = hs_blank_d + H_FPORCH[load_fmt];
	assign he_sync_d  = hs_sync_d + H_SYNC_PW[load_fmt];
	assign he_blank_d = he_sync_d + H_BPORCH[load_fmt]; // Last pixel of the line
	assign vs_blank_d = V_LINES[load_fmt] - CNT_W'(1);
	assign vs_sync_d  = vs_blank_d + V_FPORCH[load_fmt];
	assign ve_sync_d  = vs_sync_d + V_SYNC_PW[load_fmt];
	assign ve_blank_d = ve_sync_d + V_BPORCH[load_fmt]; // Last line of the frame

	always_ff @(posedge clk50m_bufg) begin
		if (load_en) begin
			hs_blank  <= hs_blank_d;
			hs_sync   <= hs_sync_d;
			he_sync   <= he_sync_d;
			he_blank  <= he_blank_d;
			vs_blank  <= vs_blank_d;
			vs_sync   <= vs_sync_d;
			ve_sync   <= ve_sync_d;
			ve_blank  <= ve_blank_d;
			sync_neg  <= SYNC_NEG[load_fmt];
			bar_width <= BAR_WIDTH[load_fmt];
			pclk_m    <= PCLK_M[load_fmt];  // To DCM M
			pclk_d    <= PCLK_D[load_fmt];  // To DCM D
		end
	end

	// Raster restarts together with the new limits
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			restart <= 1'b0;
		end else begin
			restart <= sw_changed;
		end
	end

	// Restart only with the settings of the code just accepted
	assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		restart |-> $past(sw_changed) && (pclk_m == PCLK_M[decode_format(sw_stable)]));

endmodule

// ==== timing/timing_gen.sv ====
`timescale 1ns/1ps

module timing_gen (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  logic                        restart,
	input  logic [video_pkg::CNT_W-1:0] hs_blank,
	input  logic [video_pkg::CNT_W-1:0] hs_sync,
	input  logic [video_pkg::CNT_W-1:0] he_sync,
	input  logic [video_pkg::CNT_W-1:0] he_blank,
	input  logic [video_pkg::CNT_W-1:0] vs_blank,
	input  logic [video_pkg::CNT_W-1:0] vs_sync,
	input  logic [video_pkg::CNT_W-1:0] ve_sync,
	input  logic [video_pkg::CNT_W-1:0] ve_blank,
	output logic [video_pkg::CNT_W-1:0] hcount,
	output logic [video_pkg::CNT_W-1:0] vcount,
	output logic                        hblank,
	output logic                        vblank,
	output logic                        hsync_raw,
	output logic                        vsync_raw
);

	import video_pkg::*;

	logic h_end; // Last pixel of the line
	logic v_end; // Last line of the frame

	// Compare with >= so a shrunken limit never lets the counter run away
	assign h_end = (hcount >= he_blank);
	assign v_end = (vcount >= ve_blank);

	////////////////////
	// Raster counters
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart) begin
			hcount <= '0;
			vcount <= '0;
		end else if (h_end) begin
			hcount <= '0;
			if (v_end) begin
				vcount <= '0; // New frame
			end else begin
				vcount <= vcount + CNT_W'(1);
			end
		end else begin
			hcount <= hcount + CNT_W'(1);
		end
	end

	////////////////////
	// Blanking and sync
	////////////////////
	assign hblank    = (hcount > hs_blank);
	assign hsync_raw = (hcount > hs_sync) && (hcount <= he_sync); // Active high here

	assign vblank    = (vcount > vs_blank);
	assign vsync_raw = (vcount > vs_sync) && (vcount <= ve_sync);

	// Old position may sit outside the new raster only around a restart
	assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!restart && !$past(restart) |-> (hcount <= he_blank) && (vcount <= ve_blank));

endmodule

// ==== timing/video_output_stage.sv ====
`timescale 1ns/1ps

module video_output_stage (
	input  logic                          clk50m_bufg,
	input  logic                          RSTBTN,
	input  logic                          hblank,
	input  logic                          vblank,
	input  logic                          hsync_raw,
	input  logic                          vsync_raw,
	input  logic                          sync_neg,
	input  logic [video_pkg::CNT_W-1:0]   bar_width,
	output logic                          hsync,
	output logic                          vsync,
	output logic                          de,
	output logic [video_pkg::COLOR_W-1:0] red,
	output logic [video_pkg::COLOR_W-1:0] green,
	output logic [video_pkg::COLOR_W-1:0] blue
);

	import video_pkg::*;

	localparam int RGB_W = 3 * COLOR_W;

	logic [CNT_W-1:0] bar_pix;     // Pixel within the current bar
	logic [2:0]       bar_idx;     // Palette entry
	logic [CNT_W-1:0] bar_width_q; // Previous width, flags a format switch
	logic             active;
	logic [RGB_W-1:0] rgb_src;
	logic             hs_s1;       // First pipeline stage
	logic             vs_s1;
	logic             de_s1;
	logic [RGB_W-1:0] rgb_s1;

	////////////////////
	// Colour bars
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		bar_width_q <= bar_width;
	end

	// A new width means the raster restarted at pixel 0
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || hblank || (bar_width != bar_width_q)) begin
			bar_pix <= '0;
			bar_idx <= '0;
		end else if (bar_pix == bar_width - CNT_W'(1)) begin
			bar_pix <= '0;
			bar_idx <= bar_idx + 3'd1; // Next bar
		end else begin
			bar_pix <= bar_pix + CNT_W'(1);
		end
	end

	assign active  = !hblank && !vblank;
	assign rgb_src = active ? BAR_RGB[bar_idx] : '0; // Black outside the live area

	////////////////////
	// Output pipeline
	////////////////////
	// Two stages for sync, de and colour alike
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hs_s1  <= sync_neg; // Inactive level
			vs_s1  <= sync_neg;
			de_s1  <= 1'b0;
			rgb_s1 <= '0;
			hsync  <= sync_neg;
			vsync  <= sync_neg;
			de     <= 1'b0;
			red    <= '0;
			green  <= '0;
			blue   <= '0;
		end else begin
			hs_s1  <= hsync_raw ^ sync_neg; // Format polarity
			vs_s1  <= vsync_raw ^ sync_neg;
			de_s1  <= active;
			rgb_s1 <= rgb_src;
			hsync  <= hs_s1;
			vsync  <= vs_s1;
			de     <= de_s1;
			red    <= rgb_s1[RGB_W-1 -: COLOR_W];
			green  <= rgb_s1[2*COLOR_W-1 -: COLOR_W];
			blue   <= rgb_s1[COLOR_W-1:0];
		end
	end

endmodule

// ==== logic/video_timing_top.sv ====
`timescale 1ns/1ps

module video_timing_top #(
	parameter int DEBOUNCE_CYCLES = 500000
) (
	input  logic                            clk50m_bufg,
	input  logic                            RSTBTN,
	input  logic [video_pkg::SW_W-1:0]      sw,
	output logic                            hsync,
	output logic                            vsync,
	output logic                            de,
	output logic [video_pkg::COLOR_W-1:0]   red,
	output logic [video_pkg::COLOR_W-1:0]   green,
	output logic [video_pkg::COLOR_W-1:0]   blue,
	output logic [video_pkg::CLK_SET_W-1:0] pclk_m,
	output logic [video_pkg::CLK_SET_W-1:0] pclk_d
);

	import video_pkg::*;

	logic [SW_W-1:0]  sw_stable;  // Debounced code
	logic             sw_changed;
	logic             restart;
	logic [CNT_W-1:0] hs_blank;   // Horizontal limits
	logic [CNT_W-1:0] hs_sync;
	logic [CNT_W-1:0] he_sync;
	logic [CNT_W-1:0] he_blank;
	logic [CNT_W-1:0] vs_blank;   // Vertical limits
	logic [CNT_W-1:0] vs_sync;
	logic [CNT_W-1:0] ve_sync;
	logic [CNT_W-1:0] ve_blank;
	logic             sync_neg;
	logic [CNT_W-1:0] bar_width;
	logic             hblank;
	logic             vblank;
	logic             hsync_raw;
	logic             vsync_raw;

	////////////////////
	// Format control
	////////////////////
	switch_conditioner #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_switch_conditioner (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw         (sw),
		.sw_stable  (sw_stable),
		.sw_changed (sw_changed)
	);

	format_select u_format_select (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw_stable  (sw_stable),
		.sw_changed (sw_changed),
		.hs_blank   (hs_blank),
		.hs_sync    (hs_sync),
		.he_sync    (he_sync),
		.he_blank   (he_blank),
		.vs_blank   (vs_blank),
		.vs_sync    (vs_sync),
		.ve_sync    (ve_sync),
		.ve_blank   (ve_blank),
		.sync_neg   (sync_neg),
		.bar_width  (bar_width),
		.pclk_m     (pclk_m),
		.pclk_d     (pclk_d),
		.restart    (restart)
	);

	////////////////////
	// Raster and pixels
	////////////////////
	timing_gen u_timing_gen (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.restart    (restart),
		.hs_blank   (hs_blank),
		.hs_sync    (hs_sync),
		.he_sync    (he_sync),
		.he_blank   (he_blank),
		.vs_blank   (vs_blank),
		.vs_sync    (vs_sync),
		.ve_sync    (ve_sync),
		.ve_blank   (ve_blank),
		.hcount     (),
		.vcount     (),
		.hblank     (hblank),
		.vblank     (vblank),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw)
	);

	video_output_stage u_video_output_stage (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.hblank     (hblank),
		.vblank     (vblank),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.sync_neg   (sync_neg),
		.bar_width  (bar_width),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de),
		.red        (red),
		.green      (green),
		.blue       (blue)
	);

endmodule

// ==== verification/tb_video_model.svh ====
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

////////////////////
// Reference model
////////////////////
// Active pixels, porches and sync make up a line
function automatic int line_cycles(input video_format_e fmt);
	return int'(H_PIXELS[fmt]) + int'(H_FPORCH[fmt]) + int'(H_SYNC_PW[fmt])
		+ int'(H_BPORCH[fmt]);
endfunction

function automatic int frame_lines(input video_format_e fmt);
	return int'(V_LINES[fmt]) + int'(V_FPORCH[fmt]) + int'(V_SYNC_PW[fmt])
		+ int'(V_BPORCH[fmt]);
endfunction

function automatic int frame_cycles(input video_format_e fmt);
	return line_cycles(fmt) * frame_lines(fmt);
endfunction

function automatic int active_pixels(input video_format_e fmt);
	return int'(H_PIXELS[fmt]);
endfunction

function automatic int active_lines(input video_format_e fmt);
	return int'(V_LINES[fmt]);
endfunction

function automatic int vsync_cycles(input video_format_e fmt);
	return int'(V_SYNC_PW[fmt]) * line_cycles(fmt); // Whole lines of sync
endfunction

// Level outside the sync pulse, high for negative sync
function automatic logic sync_idle(input video_format_e fmt);
	return SYNC_NEG[fmt];
endfunction

// Eight equal bars across the live line
function automatic logic [3*COLOR_W-1:0] bar_colour(input video_format_e fmt, input int pix);
	int bar_w;
	bar_w = active_pixels(fmt) / 8;
	if (pix >= active_pixels(fmt)) begin
		return '0; // Past the live line
	end
	return BAR_RGB[pix / bar_w];
endfunction

////////////////////
// Checks
////////////////////
task automatic report_mismatch(input string test, input int expected, input int actual);
	$display("error %s: expected %0d, actual %0d", test, expected, actual);
	value_errors++;
endtask

task automatic report_failure(input string what);
	$display("failure: %s", what);
	other_errors++;
endtask

// One line from a sync start to the next, counting de and sync cycles
task automatic measure_line(input video_format_e fmt, output int cycles, output int de_cnt,
		output int sync_w);
	logic idle;
	logic act;
	logic prev_act;
	logic done;
	idle     = sync_idle(fmt);
	prev_act = 1'b1; // Skip a pulse already running
	done     = 1'b0;
	while (!done) begin
		@(posedge clk50m_bufg);
		act      = (hsync != idle);
		done     = act && !prev_act;
		prev_act = act;
	end
	cycles = 1;
	sync_w = 1;
	de_cnt = de;
	done   = 1'b0;
	while (!done) begin
		@(posedge clk50m_bufg);
		act = (hsync != idle);
		if (act && !prev_act) begin
			done = 1'b1; // Next line begins
		end else begin
			cycles++;
			sync_w += act;
			de_cnt += de;
		end
		prev_act = act;
	end
endtask

`endif

// ==== verification/tb_video_timing.sv ====
`timescale 1ns/1ps

module tb_video_timing;

	import video_pkg::*;

	localparam int DEBOUNCE       = 16;
	localparam int TIMEOUT_CYCLES = 1_200_000; // One VGA frame plus short line tests, wide margin

	logic                 clk50m_bufg = 1'b0;
	logic                 RSTBTN;
	logic [SW_W-1:0]      sw;
	logic                 hsync;
	logic                 vsync;
	logic                 de;
	logic [COLOR_W-1:0]   red;
	logic [COLOR_W-1:0]   green;
	logic [COLOR_W-1:0]   blue;
	logic [CLK_SET_W-1:0] pclk_m;
	logic [CLK_SET_W-1:0] pclk_d;

	int            value_errors = 0;
	int            other_errors = 0;
	int            cycle_cnt    = 0;
	integer        seed         = 32'h37432e2b; // Bounce lengths
	logic          color_check_en;
	video_format_e color_fmt;
	int            pix_idx      = 0;  // de pixel within the line
	logic          line_armed   = 1'b0;

	`include "tb_video_model.svh"

	video_timing_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE)
	) u_video_timing_top (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw         (sw),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de),
		.red        (red),
		.green      (green),
		.blue       (blue),
		.pclk_m     (pclk_m),
		.pclk_d     (pclk_d)
	);

	always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

	task automatic print_error_counts();
		$display("Closing count: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
	endtask

	////////////////////
	// Colour compare
	////////////////////
	// Only whole lines are checked, armed while de is low
	always @(posedge clk50m_bufg) begin
		if (!de) begin
			pix_idx    <= 0;
			line_armed <= color_check_en;
		end else begin
			if (line_armed && ({red, green, blue} != bar_colour(color_fmt, pix_idx))) begin
				report_mismatch($sformatf("colour pixel %0d", pix_idx),
					bar_colour(color_fmt, pix_idx), {red, green, blue});
			end
			pix_idx <= pix_idx + 1;
		end
	end

	always @(posedge clk50m_bufg) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			print_error_counts();
			$display("Errors found");
			$finish;
		end
	end

	// Full frame from the first live pixel, right after reset
	task automatic measure_frame(input video_format_e fmt);
		logic idle;
		logic prev_de;
		logic prev_hs;
		logic hs_act;
		logic vs_act;
		logic vs_seen;
		logic done;
		int   cyc;
		int   lines;
		int   de_run;
		int   vs_cyc;
		int   hs_start;
		int   hs_w;
		idle    = sync_idle(fmt);
		prev_de = 1'b1;
		@(posedge clk50m_bufg);
		while (!de || prev_de) begin
			prev_de = de;
			@(posedge clk50m_bufg);
		end
		{prev_de, prev_hs, vs_seen, done} = '0;
		{cyc, lines, de_run, vs_cyc, hs_w} = '0;
		hs_start = -1;
		while (!done) begin
			hs_act = (hsync != idle);
			vs_act = (vsync != idle);
			if (de && !prev_de && vs_seen && !vs_act) begin
				done = 1'b1; // Next frame starts
			end else begin
				if (de && !prev_de) lines++;
				if (de) de_run++;
				if (!de && prev_de) begin
					if (de_run != active_pixels(fmt)) report_mismatch("de per line",
						active_pixels(fmt), de_run);
					de_run = 0;
				end
				if (vs_act) begin
					vs_cyc++;
					vs_seen = 1'b1;
				end
				if (hs_act && !prev_hs) begin
					if (hs_start >= 0 && cyc - hs_start != line_cycles(fmt))
						report_mismatch("hsync period", line_cycles(fmt), cyc - hs_start);
					hs_start = cyc;
					hs_w     = 0;
				end
				if (hs_act) hs_w++;
				if (!hs_act && prev_hs && hs_w != int'(H_SYNC_PW[fmt]))
					report_mismatch("hsync width", H_SYNC_PW[fmt], hs_w);
				cyc++;
				prev_de = de;
				prev_hs = hs_act;
				@(posedge clk50m_bufg);
			end
		end
		if (cyc != frame_cycles(fmt)) report_mismatch("frame length", frame_cycles(fmt), cyc);
		if (lines != active_lines(fmt)) report_mismatch("de lines", active_lines(fmt), lines);
		if (vs_cyc != vsync_cycles(fmt)) report_mismatch("vsync width", vsync_cycles(fmt), vs_cyc);
	endtask

	////////////////////
	// Stimulus
	////////////////////
	initial begin
		int cyc;
		int de_cnt;
		int sync_w;
		int pulse;
		RSTBTN         = 1'b1;
		sw             = '0;
		color_check_en = 1'b1; // VGA frame carries the bar check
		color_fmt      = fmt_vga;
		repeat (8) @(posedge clk50m_bufg);
		RSTBTN <= 1'b0;

		// VGA after reset
		@(posedge clk50m_bufg);
		if (pclk_m != PCLK_M[fmt_vga]) report_mismatch("vga pclk_m", PCLK_M[fmt_vga], pclk_m);
		if (pclk_d != PCLK_D[fmt_vga]) report_mismatch("vga pclk_d", PCLK_D[fmt_vga], pclk_d);
		if (hsync != sync_idle(fmt_vga)) report_failure("hsync does not idle high under VGA");
		measure_frame(fmt_vga);

		// SVGA, switch only during blanking
		color_check_en <= 1'b0;
		@(posedge clk50m_bufg);
		while (de) @(posedge clk50m_bufg);
		sw <= 4'b0001;
		repeat (200) @(posedge clk50m_bufg);
		if (pclk_m != PCLK_M[fmt_svga]) report_mismatch("svga pclk_m", PCLK_M[fmt_svga], pclk_m);
		if (pclk_d != PCLK_D[fmt_svga]) report_mismatch("svga pclk_d", PCLK_D[fmt_svga], pclk_d);
		while (!de) @(posedge clk50m_bufg);
		if (hsync != sync_idle(fmt_svga)) report_failure("hsync is not active high under SVGA");
		measure_line(fmt_svga, cyc, de_cnt, sync_w);
		if (cyc != line_cycles(fmt_svga)) report_mismatch("svga line", line_cycles(fmt_svga), cyc);
		if (de_cnt != active_pixels(fmt_svga))
			report_mismatch("svga de", active_pixels(fmt_svga), de_cnt);
		if (sync_w != int'(H_SYNC_PW[fmt_svga]))
			report_mismatch("svga hsync width", H_SYNC_PW[fmt_svga], sync_w);

		// Short bounces toward XGA must be ignored
		repeat (8) begin
			pulse = 1 + int'($unsigned($random(seed)) % 15);
			@(posedge clk50m_bufg);
			sw <= 4'b0011;
			repeat (pulse) @(posedge clk50m_bufg);
			sw <= 4'b0001;
			repeat (DEBOUNCE + 8) @(posedge clk50m_bufg);
		end
		if (pclk_m != PCLK_M[fmt_svga]) report_mismatch("bounce pclk_m", PCLK_M[fmt_svga], pclk_m);
		measure_line(fmt_svga, cyc, de_cnt, sync_w);
		if (cyc != line_cycles(fmt_svga)) report_mismatch("bounce line", line_cycles(fmt_svga), cyc);

		// Undefined code runs as 720p
		@(posedge clk50m_bufg);
		sw <= 4'b0111;
		repeat (200) @(posedge clk50m_bufg);
		if (pclk_m != PCLK_M[fmt_hdtv720p])
			report_mismatch("720p pclk_m", PCLK_M[fmt_hdtv720p], pclk_m);
		if (pclk_d != PCLK_D[fmt_hdtv720p])
			report_mismatch("720p pclk_d", PCLK_D[fmt_hdtv720p], pclk_d);
		color_fmt      <= fmt_hdtv720p;
		color_check_en <= 1'b1;
		repeat (3) begin
			measure_line(fmt_hdtv720p, cyc, de_cnt, sync_w);
			if (cyc != line_cycles(fmt_hdtv720p))
				report_mismatch("720p line", line_cycles(fmt_hdtv720p), cyc);
			if (de_cnt != active_pixels(fmt_hdtv720p))
				report_mismatch("720p de", active_pixels(fmt_hdtv720p), de_cnt);
		end
		color_check_en <= 1'b0;

		print_error_counts();
		if (value_errors == 0 && other_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+verification
common/video_pkg.sv
logic/switch_conditioner.sv
logic/format_select.sv
timing/timing_gen.sv
timing/video_output_stage.sv
logic/video_timing_top.sv
verification/tb_video_timing.sv

// ==== Bender.yml ====
package:
  name: video_timing

sources:
  - files:
      - common/video_pkg.sv
      - logic/switch_conditioner.sv
      - logic/format_select.sv
      - timing/timing_gen.sv
      - timing/video_output_stage.sv
      - logic/video_timing_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_video_timing.sv
